// File: Bender.yml
package:
  name: ew_video

sources:
  - hw/ew_pkg.sv
  - hw/reset_lock.sv
  - hw/vga_timing.sv
  - hw/texture_gen.sv
  - hw/gpout_mux.sv
  - hw/axil_regs.sv
  - hw/ew_video_top.sv
  - target: test
    files:
      - dv/tb_ew_video.sv

// File: compile.f
hw/ew_pkg.sv
hw/reset_lock.sv
hw/vga_timing.sv
hw/texture_gen.sv
hw/gpout_mux.sv
hw/axil_regs.sv
hw/ew_video_top.sv
dv/tb_ew_video.sv

// File: dv/tb_ew_video.sv
`timescale 1ns/1ps

module tb_ew_video import ew_pkg::*; ();

    localparam real CLK_HALF  = 2.0;             // 4 ns period
    localparam int  FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int  TEX_CYC   = 300 * H_TOTAL;   // Lines checked per mode
    localparam int  AXI_LIMIT = 64;              // Cycles allowed per AXI access
    // Search plus one measured frame, three texture spans, register traffic
    localparam real WATCHDOG_NS = (3.0 * FRAME_CYC + 3.0 * TEX_CYC + 20000.0) * 2.0 * CLK_HALF;

    logic clk, i_rst, i_lock_a, i_lock_b;
    axil_addr_t i_axil_awaddr, i_axil_araddr;
    axil_data_t i_axil_wdata, o_axil_rdata;
    logic [3:0] i_axil_wstrb;
    logic i_axil_awvalid, i_axil_wvalid, i_axil_bready, i_axil_arvalid, i_axil_rready;
    logic o_axil_awready, o_axil_wready, o_axil_bvalid, o_axil_arready, o_axil_rvalid;
    logic [1:0] o_axil_bresp, o_axil_rresp;
    logic o_reset, o_hsync, o_vsync;
    rgb24_t o_rgb;
    logic [N_GPOUT-1:0] o_gpout;

    int          errors;     // Failed compares
    int          timeouts;   // Handshakes that never finished
    logic        aligned;    // Model tracks the output beat
    pos_t        m_col;      // Column of the beat on the outputs
    pos_t        m_row;
    mode_t       mode_cur;   // Last mode written
    logic [31:0] reg_exp [7];

    ew_video_top ew_video_top_i (
        .clk, .i_rst, .i_lock_a, .i_lock_b,
        .i_axil_awaddr, .i_axil_awvalid, .o_axil_awready,
        .i_axil_wdata, .i_axil_wstrb, .i_axil_wvalid, .o_axil_wready,
        .o_axil_bresp, .o_axil_bvalid, .i_axil_bready,
        .i_axil_araddr, .i_axil_arvalid, .o_axil_arready,
        .o_axil_rdata, .o_axil_rresp, .o_axil_rvalid, .i_axil_rready,
        .o_reset, .o_hsync, .o_vsync, .o_rgb, .o_gpout
    );

    always #(CLK_HALF) clk = ~clk;

    // Raster position model, advances with every output beat once aligned
    always @(posedge clk) begin
        if (aligned) begin
            if (m_col == pos_t'(H_TOTAL - 1)) begin
                m_col <= '0;
                m_row <= (m_row == pos_t'(V_TOTAL - 1)) ? pos_t'(0) : m_row + 1'b1;
            end else begin
                m_col <= m_col + 1'b1;
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #0.5; // Drive and sample point
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
        end
    endtask

    // BGR888 colour from the texture rule, black in blanking
    function automatic rgb24_t expected_rgb(pos_t col, pos_t row, mode_t mode);
        logic [1:0] r;
        logic [1:0] g;
        logic       b;
        if (col >= H_ACTIVE || row >= V_ACTIVE) return '0;
        r = col[6:5] ^ {2{mode[0]}};
        g = row[6:5] ^ {2{mode[1]}};
        b = mode[2] ? (col[3] ^ row[3]) : (col[7] ^ row[7]); // Fine or coarse checker
        return {b, b, 6'b0, g, 6'b0, r, 6'b0};
    endfunction

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output logic [1:0] resp);
        logic aw_ack, w_ack;
        int   n;
        n              = 0;
        resp           = 2'bxx;
        i_axil_awaddr  = addr;
        i_axil_wdata   = data;
        i_axil_wstrb   = 4'hf;
        i_axil_awvalid = 1'b1;
        i_axil_wvalid  = 1'b1;
        while ((i_axil_awvalid || i_axil_wvalid) && n < AXI_LIMIT) begin
            aw_ack = o_axil_awready; // Handshake taken on the coming edge
            w_ack  = o_axil_wready;
            tick();
            if (aw_ack) i_axil_awvalid = 1'b0;
            if (w_ack)  i_axil_wvalid  = 1'b0;
            n++;
        end
        i_axil_bready = 1'b1;
        while (!o_axil_bvalid && n < AXI_LIMIT) begin
            tick();
            n++;
        end
        if (n >= AXI_LIMIT) begin
            timeouts++;
            $display("AXI write to address 0x%0h never got a response", addr);
            i_axil_awvalid = 1'b0;
            i_axil_wvalid  = 1'b0;
        end else begin
            resp = o_axil_bresp;
        end
        tick();
        i_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output logic [1:0] resp);
        logic ar_ack;
        int   n;
        n              = 0;
        data           = 'x;
        resp           = 2'bxx;
        i_axil_araddr  = addr;
        i_axil_arvalid = 1'b1;
        while (i_axil_arvalid && n < AXI_LIMIT) begin
            ar_ack = o_axil_arready;
            tick();
            if (ar_ack) i_axil_arvalid = 1'b0;
            n++;
        end
        i_axil_rready = 1'b1;
        while (!o_axil_rvalid && n < AXI_LIMIT) begin
            tick();
            n++;
        end
        if (n >= AXI_LIMIT) begin
            timeouts++;
            $display("AXI read from address 0x%0h never got a response", addr);
            i_axil_arvalid = 1'b0;
        end else begin
            data = o_axil_rdata;
            resp = o_axil_rresp;
        end
        tick();
        i_axil_rready = 1'b0;
    endtask

    task automatic set_sel(input int lane, input sel_t sel);
        logic [1:0] resp;
        axil_write(axil_addr_t'(4 * (lane + 1)), axil_data_t'(sel), resp);
        check_value("bresp", resp, RESP_OKAY);
    endtask

    task automatic hold_and_release_lock();
        axil_data_t rdata;
        logic [1:0] resp;
        repeat (8) begin // Locks equal, video held
            tick();
            check_value("o_reset", o_reset, 1'b1);
            check_value("o_hsync", o_hsync, 1'b1);
            check_value("o_vsync", o_vsync, 1'b1);
            check_value("o_rgb", o_rgb, '0);
        end
        axil_read(5'h1c, rdata, resp);
        check_value("status", rdata, 32'h1);
        i_lock_a = 1'b1; // Locks now oppose
        tick();
        check_value("o_reset", o_reset, 1'b1);
        tick();
        check_value("o_reset", o_reset, 1'b0); // Released after exactly 2 cycles
        axil_read(5'h1c, rdata, resp);
        check_value("status", rdata, 32'h0);
        check_value("rresp", resp, RESP_OKAY);
    endtask

    task automatic readback_all();
        axil_data_t rdata;
        logic [1:0] resp;
        int         i;
        for (i = 0; i < 7; i++) begin
            axil_read(axil_addr_t'(4 * i), rdata, resp);
            check_value("rdata", rdata, reg_exp[i]);
            check_value("rresp", resp, RESP_OKAY);
        end
    endtask

    task automatic write_and_read_registers();
        axil_data_t data, rdata;
        logic [1:0] resp;
        int         i;
        for (i = 0; i < 7; i++) begin
            data = $urandom;
            axil_write(axil_addr_t'(4 * i), data, resp);
            check_value("bresp", resp, RESP_OKAY);
            reg_exp[i] = data & ((i == 0) ? 32'h7 : 32'h3f); // Mode 3 bits, selects 6 bits
        end
        readback_all();
        axil_write(5'h1c, 32'hffff_ffff, resp); // Status is read-only
        check_value("bresp", resp, RESP_SLVERR);
        axil_write(5'h16, 32'hffff_ffff, resp); // Misaligned, inside lane 4 select
        check_value("bresp", resp, RESP_SLVERR);
        axil_read(5'h1e, rdata, resp);
        check_value("rresp", resp, RESP_SLVERR);
        readback_all(); // Nothing changed
    endtask

    // Finds a falling edge, then counts the low time and the full period
    task automatic measure_sync(input logic is_v, output int low, output int period);
        while ((is_v ? o_vsync : o_hsync) === 1'b0) tick();
        while ((is_v ? o_vsync : o_hsync) === 1'b1) tick();
        low = 0;
        while ((is_v ? o_vsync : o_hsync) === 1'b0) begin
            tick();
            low++;
        end
        period = low;
        while ((is_v ? o_vsync : o_hsync) === 1'b1) begin
            tick();
            period++;
        end
    endtask

    task automatic time_syncs_and_align();
        int low, period;
        measure_sync(1'b0, low, period);
        check_value("hsync low cycles", low, H_SYNC);
        check_value("hsync period", period, H_TOTAL);
        measure_sync(1'b1, low, period);
        check_value("vsync low cycles", low, V_SYNC * H_TOTAL);
        check_value("vsync period", period, FRAME_CYC);
        // Now at column 0 of the first vsync row, next hsync fall is column 656
        while (o_hsync !== 1'b0) tick();
        m_col   = pos_t'(H_ACTIVE + H_FRONT);
        m_row   = pos_t'(V_ACTIVE + V_FRONT);
        aligned = 1'b1;
    endtask

    task automatic compare_texture();
        mode_t      modes [3] = '{3'd0, 3'd3, 3'd4};
        logic [1:0] resp;
        int         i;
        for (i = 0; i < 3; i++) begin
            axil_write(5'h00, axil_data_t'(modes[i]), resp);
            check_value("bresp", resp, RESP_OKAY);
            mode_cur = modes[i];
            repeat (TEX_CYC) begin
                tick();
                check_value("o_rgb", o_rgb, expected_rgb(m_col, m_row, mode_cur));
            end
        end
    endtask

    task automatic sweep_probe_selects();
        logic [N_GPOUT-1:0] s0, s1;
        rgb24_t             e;
        int                 g;
        for (g = 0; g < N_GPOUT; g++) set_sel(g, sel_t'(44 + g)); // hpos bits 0..5
        repeat (64) begin
            tick();
            check_value("o_gpout", o_gpout, m_col[5:0]);
        end
        for (g = 0; g < N_GPOUT; g++) set_sel(g, 6'd2); // clk/4 on every lane
        tick();
        s0 = o_gpout;
        tick();
        s1 = o_gpout;
        repeat (16) begin
            tick();
            check_value("o_gpout", o_gpout, {N_GPOUT{~s0[0]}}); // Flips every 2 cycles
            s0 = s1;
            s1 = o_gpout;
        end
        set_sel(1, 6'd1); // Alt lanes 1 and 2 carry the lock pair
        set_sel(2, 6'd1);
        check_value("o_gpout[2:1]", o_gpout[2:1], {i_lock_b, i_lock_a});
        i_lock_a = 1'b0; // Swap both at once, still opposed
        i_lock_b = 1'b1;
        #1;
        check_value("o_gpout[2:1]", o_gpout[2:1], {i_lock_b, i_lock_a});
        tick();
        check_value("o_reset", o_reset, 1'b0);
        for (g = 0; g < N_GPOUT; g++) set_sel(g, 6'd0);
        repeat (32) begin
            tick();
            e = expected_rgb(m_col, m_row, mode_cur);
            check_value("o_gpout", o_gpout, {e[23], e[22], e[7], e[6], e[15], e[14]});
        end
        for (g = 0; g < N_GPOUT; g++) set_sel(g, 6'd40); // Unused source
        repeat (8) begin
            tick();
            check_value("o_gpout", o_gpout, '0);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        i_rst          = 1'b1;
        i_lock_a       = 1'b0; // Equal locks keep the video in reset
        i_lock_b       = 1'b0;
        i_axil_awaddr  = '0;
        i_axil_awvalid = 1'b0;
        i_axil_wdata   = '0;
        i_axil_wstrb   = '0;
        i_axil_wvalid  = 1'b0;
        i_axil_bready  = 1'b0;
        i_axil_araddr  = '0;
        i_axil_arvalid = 1'b0;
        i_axil_rready  = 1'b0;
        errors         = 0;
        timeouts       = 0;
        aligned        = 1'b0;
        m_col          = '0;
        m_row          = '0;
        mode_cur       = '0;
        void'($urandom(32'h696098c1));
        repeat (5) tick();
        i_rst = 1'b0;
        hold_and_release_lock();
        write_and_read_registers();
        time_syncs_and_align();
        compare_texture();
        sweep_probe_selects();
        $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: hw/axil_regs.sv
`timescale 1ns/1ps

module axil_regs import ew_pkg::*; (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_video_rst,   // Status bit 0
    input  axil_addr_t i_axil_awaddr,
    input  logic       i_axil_awvalid,
    output logic       o_axil_awready,
    input  axil_data_t i_axil_wdata,
    input  logic [3:0] i_axil_wstrb,
    input  logic       i_axil_wvalid,
    output logic       o_axil_wready,
    output logic [1:0] o_axil_bresp,
    output logic       o_axil_bvalid,
    input  logic       i_axil_bready,
    input  axil_addr_t i_axil_araddr,
    input  logic       i_axil_arvalid,
    output logic       o_axil_arready,
    output axil_data_t o_axil_rdata,
    output logic [1:0] o_axil_rresp,
    output logic       o_axil_rvalid,
    input  logic       i_axil_rready,
    output ew_cfg_t    o_cfg
);

    typedef enum logic {W_IDLE, W_RESP} wr_state_t;
    typedef enum logic {R_IDLE, R_RESP} rd_state_t;

    wr_state_t  wr_state;
    rd_state_t  rd_state;
    ew_cfg_t    cfg_q;
    logic       aw_seen, w_seen;  // Halves of a write already taken
    axil_addr_t aw_addr_q;
    axil_data_t w_data_q;
    logic       w_strb0_q;
    logic       aw_hs, w_hs;
    axil_addr_t wr_addr;          // Address and data of the write in hand
    axil_data_t wr_data;
    logic       wr_strb0;
    logic [2:0] wr_idx, rd_idx;

    // Ready only in idle and only for a half not yet held
    assign o_axil_awready = (wr_state == W_IDLE) && !aw_seen;
    assign o_axil_wready  = (wr_state == W_IDLE) && !w_seen;
    assign o_axil_bvalid  = (wr_state == W_RESP);
    assign o_axil_arready = (rd_state == R_IDLE);
    assign o_axil_rvalid  = (rd_state == R_RESP);
    assign aw_hs = i_axil_awvalid && o_axil_awready;
    assign w_hs  = i_axil_wvalid && o_axil_wready;

    // Take the latched half if held, else the live bus
    assign wr_addr  = aw_seen ? aw_addr_q : i_axil_awaddr;
    assign wr_data  = w_seen ? w_data_q : i_axil_wdata;
    assign wr_strb0 = w_seen ? w_strb0_q : i_axil_wstrb[0];
    assign wr_idx   = wr_addr[4:2];
    assign rd_idx   = i_axil_araddr[4:2];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_state <= W_IDLE;
            aw_seen  <= 1'b0;
            w_seen   <= 1'b0;
            cfg_q    <= '0;
        end else if (wr_state == W_IDLE) begin
            if ((aw_seen || aw_hs) && (w_seen || w_hs)) begin
                wr_state <= W_RESP; // Both halves here, commit
                aw_seen  <= 1'b0;
                w_seen   <= 1'b0;
                if (wr_addr[1:0] != 2'b00 || wr_idx == REG_STATUS) begin
                    o_axil_bresp <= RESP_SLVERR; // Misaligned or read-only
                end else begin
                    o_axil_bresp <= RESP_OKAY;
                    if (wr_strb0 && wr_idx == REG_MODE) cfg_q.mode <= wr_data[2:0];
                    else if (wr_strb0) cfg_q.sel[3'(wr_idx - 3'd1)] <= wr_data[5:0];
                end
            end else begin
                aw_seen <= aw_seen | aw_hs;
                w_seen  <= w_seen | w_hs;
            end
        end else if (i_axil_bready) begin
            wr_state <= W_IDLE;
        end
    end

    // Payload of each half, no reset
    always_ff @(posedge clk) begin
        if (aw_hs) aw_addr_q <= i_axil_awaddr;
        if (w_hs) begin
            w_data_q  <= i_axil_wdata;
            w_strb0_q <= i_axil_wstrb[0];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rd_state <= R_IDLE;
        end else if (rd_state == R_IDLE) begin
            if (i_axil_arvalid) begin
                rd_state     <= R_RESP;
                o_axil_rresp <= RESP_OKAY;
                o_axil_rdata <= '0;
                if (i_axil_araddr[1:0] != 2'b00) o_axil_rresp <= RESP_SLVERR;
                else if (rd_idx == REG_MODE)     o_axil_rdata[2:0] <= cfg_q.mode;
                else if (rd_idx == REG_STATUS)   o_axil_rdata[0] <= i_video_rst;
                else o_axil_rdata[5:0] <= cfg_q.sel[3'(rd_idx - 3'd1)]; // Lane selects
            end
        end else if (i_axil_rready) begin
            rd_state <= R_IDLE;
        end
    end

    assign o_cfg = cfg_q;

endmodule

// File: hw/ew_pkg.sv
package ew_pkg;

    // 640x480 at 60 Hz, pixel counts
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;
    // Line counts
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    localparam int N_GPOUT = 6; // Probe lanes

    typedef logic [9:0]  pos_t;   // Column or row
    typedef logic [5:0]  rgb6_t;  // {B1,B0,G1,G0,R1,R0}
    typedef logic [23:0] rgb24_t; // BGR888
    typedef logic [5:0]  sel_t;   // Probe source index
    typedef logic [2:0]  mode_t;  // Texture control
    typedef logic [4:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // Counter compare points, already in counter width
    localparam pos_t H_LAST     = pos_t'(H_TOTAL - 1);
    localparam pos_t V_LAST     = pos_t'(V_TOTAL - 1);
    localparam pos_t H_BLANK    = pos_t'(H_ACTIVE);
    localparam pos_t V_BLANK    = pos_t'(V_ACTIVE);
    localparam pos_t H_SYNC_BEG = pos_t'(H_ACTIVE + H_FRONT);          // 656
    localparam pos_t H_SYNC_END = pos_t'(H_ACTIVE + H_FRONT + H_SYNC); // 752, exclusive
    localparam pos_t V_SYNC_BEG = pos_t'(V_ACTIVE + V_FRONT);          // 490
    localparam pos_t V_SYNC_END = pos_t'(V_ACTIVE + V_FRONT + V_SYNC); // 492, exclusive

    // AXI4-Lite response codes and register indices (addr[4:2])
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [2:0] REG_MODE    = 3'd0;
    localparam logic [2:0] REG_STATUS  = 3'd7;

    typedef struct packed {
        pos_t hpos;
        pos_t vpos;
        logic hblank;
        logic vblank;
        logic hsync_n;
        logic vsync_n;
    } video_beat_t; // 24 bits, stage 1 out

    typedef struct packed {
        video_beat_t beat;
        rgb6_t       rgb;
    } pixel_beat_t; // 30 bits, stage 2 out

    typedef struct packed {
        mode_t                    mode;
        sel_t [N_GPOUT-1:0]       sel;
    } ew_cfg_t; // 39 bits

    // Beat held while the video logic is in reset; 0,0 is an active pixel
    localparam video_beat_t BEAT_RESET = '{hpos: '0, vpos: '0, hblank: 1'b0, vblank: 1'b0,
                                           hsync_n: 1'b1, vsync_n: 1'b1};

    // Two live bits per channel go to the top of each DAC byte
    function automatic rgb24_t widen_rgb(rgb6_t c);
        return {c[5:4], 6'b0, c[3:2], 6'b0, c[1:0], 6'b0};
    endfunction

endpackage

// File: hw/ew_video_top.sv
`timescale 1ns/1ps

module ew_video_top import ew_pkg::*; (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_lock_a,       // Must oppose i_lock_b to run
    input  logic               i_lock_b,
    input  axil_addr_t         i_axil_awaddr,
    input  logic               i_axil_awvalid,
    output logic               o_axil_awready,
    input  axil_data_t         i_axil_wdata,
    input  logic [3:0]         i_axil_wstrb,
    input  logic               i_axil_wvalid,
    output logic               o_axil_wready,
    output logic [1:0]         o_axil_bresp,
    output logic               o_axil_bvalid,
    input  logic               i_axil_bready,
    input  axil_addr_t         i_axil_araddr,
    input  logic               i_axil_arvalid,
    output logic               o_axil_arready,
    output axil_data_t         o_axil_rdata,
    output logic [1:0]         o_axil_rresp,
    output logic               o_axil_rvalid,
    input  logic               i_axil_rready,
    output logic               o_reset,        // Internal video reset
    output logic               o_hsync,        // Active low
    output logic               o_vsync,        // Active low
    output rgb24_t             o_rgb,          // BGR888, low 6 bits zero
    output logic [N_GPOUT-1:0] o_gpout
);

    logic        video_rst;
    ew_cfg_t     cfg;
    video_beat_t timing_beat; // Stage 1 to stage 2
    pixel_beat_t pixel_beat;  // Stage 2 out

    reset_lock reset_lock_i (.clk, .i_rst, .i_lock_a, .i_lock_b, .o_video_rst(video_rst));

    vga_timing vga_timing_i (.clk, .i_rst(video_rst), .o_beat(timing_beat));

    texture_gen texture_gen_i (
        .clk, .i_rst(video_rst), .i_mode(cfg.mode), .i_beat(timing_beat), .o_beat(pixel_beat)
    );

    // Divider runs off the video reset too
    gpout_mux gpout_mux_i (
        .clk, .i_rst(video_rst), .i_sel(cfg.sel), .i_beat(pixel_beat), .i_mode(cfg.mode),
        .i_lock_a, .i_lock_b, .i_video_rst(video_rst), .o_gpout
    );

    // Registers reset on i_rst only, so settings survive the lock
    axil_regs axil_regs_i (
        .clk, .i_rst, .i_video_rst(video_rst),
        .i_axil_awaddr, .i_axil_awvalid, .o_axil_awready,
        .i_axil_wdata, .i_axil_wstrb, .i_axil_wvalid, .o_axil_wready,
        .o_axil_bresp, .o_axil_bvalid, .i_axil_bready,
        .i_axil_araddr, .i_axil_arvalid, .o_axil_arready,
        .o_axil_rdata, .o_axil_rresp, .o_axil_rvalid, .i_axil_rready,
        .o_cfg(cfg)
    );

    assign o_reset = video_rst;
    assign o_hsync = pixel_beat.beat.hsync_n;
    assign o_vsync = pixel_beat.beat.vsync_n;
    assign o_rgb   = widen_rgb(pixel_beat.rgb); // Pure bit placement

endmodule

// File: hw/gpout_mux.sv
`timescale 1ns/1ps

module gpout_mux import ew_pkg::*; (
    input  logic               clk,
    input  logic               i_rst,        // Clears the divider
    input  sel_t [N_GPOUT-1:0] i_sel,        // Per-lane source
    input  pixel_beat_t        i_beat,       // Current output beat
    input  mode_t              i_mode,
    input  logic               i_lock_a,
    input  logic               i_lock_b,
    input  logic               i_video_rst,  // Probe value only
    output logic [N_GPOUT-1:0] o_gpout
);

    logic [1:0]         clk_div; // Shared by all lanes
    logic [N_GPOUT-1:0] prim;    // Select 0 per lane
    logic [N_GPOUT-1:0] alt;     // Select 1 per lane
    rgb24_t             rgb24;

    always_ff @(posedge clk) begin
        if (i_rst) clk_div <= '0;
        else       clk_div <= clk_div + 1'b1;
    end

    // Lanes 0..5 carry G0,G1,R0,R1,B0,B1
    assign prim  = {i_beat.rgb[5], i_beat.rgb[4], i_beat.rgb[1], i_beat.rgb[0],
                    i_beat.rgb[3], i_beat.rgb[2]};
    assign alt   = {i_video_rst, i_beat.beat.vsync_n, i_beat.beat.hsync_n,
                    i_lock_b, i_lock_a, i_video_rst};
    assign rgb24 = widen_rgb(i_beat.rgb);

    for (genvar g = 0; g < N_GPOUT; g++) begin : g_lane
        logic lane_out;

        always_comb begin
            case (i_sel[g]) inside
                6'd0:      lane_out = prim[g];
                6'd1:      lane_out = alt[g];
                6'd2:      lane_out = clk_div[1];            // clk/4
                6'd3:      lane_out = i_beat.beat.hblank;
                6'd4:      lane_out = i_beat.beat.vblank;
                [5:7]:     lane_out = i_mode[2'(i_sel[g] - sel_t'(5))];
                [8:31]:    lane_out = rgb24[5'(i_sel[g] - sel_t'(8))];
                [44:53]:   lane_out = i_beat.beat.hpos[4'(i_sel[g] - sel_t'(44))];
                [54:63]:   lane_out = i_beat.beat.vpos[4'(i_sel[g] - sel_t'(54))];
                default:   lane_out = 1'b0;                  // 32..43 unused
            endcase
        end

        assign o_gpout[g] = lane_out;
    end

endmodule

// File: hw/reset_lock.sv
`timescale 1ns/1ps

module reset_lock import ew_pkg::*; (
    input  logic clk,
    input  logic i_rst,       // Global reset
    input  logic i_lock_a,    // Lock pair, must differ to release
    input  logic i_lock_b,
    output logic o_video_rst  // Raw reset delayed by 2 cycles
);

    logic raw_rst;
    logic rst_q1; // First stage of the chain
    logic rst_q2;

    // Held in reset while both lock inputs agree
    assign raw_rst = i_rst | (i_lock_a == i_lock_b);

    // Two flops strip any glitch from the lock inputs
    always_ff @(posedge clk) begin
        rst_q1 <= raw_rst;
        rst_q2 <= rst_q1;
    end

    assign o_video_rst = rst_q2;

endmodule

// File: hw/texture_gen.sv
`timescale 1ns/1ps

module texture_gen import ew_pkg::*; (
    input  logic        clk,
    input  logic        i_rst,   // Video reset
    input  mode_t       i_mode,  // Bit 2 fine checker, bits 1:0 invert G/R
    input  video_beat_t i_beat,  // From the timing stage
    output pixel_beat_t o_beat   // Beat plus colour, one cycle later
);

    logic       blank;
    logic       chk;    // Checker term for blue
    logic [1:0] red;
    logic [1:0] green;
    rgb6_t      colour;

    assign blank = i_beat.hblank | i_beat.vblank;

    // Coarse checker on bit 7, fine checker on bit 3
    assign chk = i_mode[2] ? (i_beat.hpos[3] ^ i_beat.vpos[3])
                           : (i_beat.hpos[7] ^ i_beat.vpos[7]);

    // Gradient steps every 32 pixels, mode bits flip them
    assign red   = i_beat.hpos[6:5] ^ {2{i_mode[0]}};
    assign green = i_beat.vpos[6:5] ^ {2{i_mode[1]}};

    always_comb begin
        if (blank) begin
            colour = '0; // Black outside the active area
        end else begin
            colour = {chk, chk, green, red};
        end
    end

    // Timing fields ride along with the colour
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_beat <= '{beat: BEAT_RESET, rgb: '0};
        end else begin
            o_beat <= '{beat: i_beat, rgb: colour};
        end
    end

endmodule

// File: hw/vga_timing.sv
`timescale 1ns/1ps

module vga_timing import ew_pkg::*; (
    input  logic        clk,
    input  logic        i_rst,  // Video reset
    output video_beat_t o_beat  // Registered timing beat
);

    pos_t        h_cnt;  // Column counter
    pos_t        v_cnt;  // Row counter
    video_beat_t beat_d; // Beat decoded from the current counts

    // Counters wrap at the end of each line and frame
    always_ff @(posedge clk) begin
        if (i_rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1; // Next line
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Blanking and syncs from the counts
    always_comb begin
        beat_d.hpos    = h_cnt;
        beat_d.vpos    = v_cnt;
        beat_d.hblank  = (h_cnt >= H_BLANK);
        beat_d.vblank  = (v_cnt >= V_BLANK);
        // Syncs are active low, 96 pixels and 2 lines
        beat_d.hsync_n = !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));
        beat_d.vsync_n = !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END));
    end

    // Whole beat registered together so all fields stay aligned
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_beat <= BEAT_RESET; // Syncs idle high
        end else begin
            o_beat <= beat_d;
        end
    end

endmodule
